// File: hdl/lsu_config.svh
`ifndef LSU_CONFIG_SVH
`define LSU_CONFIG_SVH

// core data bus width
`define LSU_DATA_W 32

// virtual and physical address width
`define LSU_ADDR_W 32

// one strobe bit per byte lane
`define LSU_STRB_W 4

`endif

// File: hdl/lsu_pkg.sv
`include "lsu_config.svh"

package lsu_pkg;

	// access size, low two bits of the type code
	localparam logic [1:0] SZ_WORD = 2'b00;
	localparam logic [1:0] SZ_HALF = 2'b01;
	localparam logic [1:0] SZ_BYTE = 2'b10;

	// bit 2 set means zero extension on loads
	typedef enum logic [2:0] {
		LW  = {1'b0, SZ_WORD},
		LH  = {1'b0, SZ_HALF},
		LB  = {1'b0, SZ_BYTE},
		LHU = {1'b1, SZ_HALF},
		LBU = {1'b1, SZ_BYTE}
	} mem_type_t;

	// stores share the signed load codes
	localparam mem_type_t SW = LW;
	localparam mem_type_t SH = LH;
	localparam mem_type_t SB = LB;

	typedef enum logic [2:0] {
		IDLE = 3'b001,
		ADDR = 3'b010,
		DATA = 3'b100
	} lsu_state_e;

	// one in-flight request
	typedef struct packed {
		logic                   valid;
		logic                   write;
		mem_type_t              mem_type;
		logic [`LSU_ADDR_W-1:0] vaddr;
		logic [`LSU_ADDR_W-1:0] paddr;
	} lsu_req_t;

endpackage

// File: hdl/lsu_req_pipe.sv
`timescale 1ns/1ps
`include "lsu_config.svh"

module lsu_req_pipe
	import lsu_pkg::*;
(
	input  logic                   clk,
	input  logic                   rst_n,

	input  logic                   req_valid_i,
	input  logic                   req_write_i,
	input  mem_type_t              req_type_i,
	input  logic [`LSU_ADDR_W-1:0] vaddr_i,
	input  logic [`LSU_ADDR_W-1:0] paddr_i,

	input  logic                   flush_m1_i,
	input  logic                   flush_m2_i,
	input  logic                   stall_i,
	input  logic                   busy_i,
	input  logic                   done_i,

	output lsu_req_t               m2_req_o,
	output logic [`LSU_ADDR_W-1:0] vaddr_o,
	output logic [`LSU_ADDR_W-1:0] paddr_o
);

	lsu_req_t m1_d;
	lsu_req_t m1_q;
	lsu_req_t m2_d;
	lsu_req_t m2_q;
	logic     flush;
	logic     advance;

	// paddr is not known yet in M1
	always_comb begin
		m1_d          = '0;
		m1_d.valid    = req_valid_i;
		m1_d.write    = req_write_i;
		m1_d.mem_type = req_type_i;
		m1_d.vaddr    = vaddr_i;
		m1_d.paddr    = vaddr_i;
	end

	// translated address joins at M2
	always_comb begin
		m2_d       = m1_q;
		m2_d.paddr = paddr_i;
	end

	assign flush   = flush_m1_i | flush_m2_i;
	assign advance = ~busy_i & ~stall_i;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			m1_q.valid <= 1'b0;
			m2_q.valid <= 1'b0;
		end else if (flush) begin
			m1_q.valid <= 1'b0;
			m2_q.valid <= 1'b0;
		end else if (done_i) begin
			// transfer finished, M1 keeps waiting
			m2_q.valid <= 1'b0;
		end else if (advance) begin
			m1_q <= m1_d;
			m2_q <= m2_d;
		end
	end

	assign m2_req_o = m2_q;
	assign vaddr_o  = m2_q.vaddr;
	assign paddr_o  = m2_q.paddr;

endmodule

// File: hdl/lsu_bus_fsm.sv
`timescale 1ns/1ps
`include "lsu_config.svh"

module lsu_bus_fsm
	import lsu_pkg::*;
(
	input  logic                   clk,
	input  logic                   rst_n,

	input  lsu_req_t               m2_req_i,
	input  logic                   flush_m2_i,

	input  logic                   bus_ready_i,
	input  logic                   bus_data_ok_i,
	output logic                   bus_valid_o,
	output logic                   bus_write_o,
	output logic [`LSU_ADDR_W-1:0] bus_addr_o,
	output logic                   bus_data_ok_o,

	output logic                   done_o,
	output logic                   busy_o
);

	lsu_state_e state_q;
	lsu_state_e state_d;

	always_comb begin
		state_d = state_q;
		case (state_q)
			IDLE: begin
				// a request flushed while still in M2 never reaches the bus
				if (m2_req_i.valid && !flush_m2_i) begin
					state_d = ADDR;
				end
			end
			ADDR: begin
				if (bus_ready_i) begin
					state_d = DATA;
				end
			end
			DATA: begin
				if (done_o) begin
					state_d = IDLE;
				end
			end
			default: begin
				state_d = IDLE;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state_q <= IDLE;
		end else begin
			state_q <= state_d;
		end
	end

	// address phase straight from the M2 record
	assign bus_valid_o   = (state_q == ADDR);
	assign bus_write_o   = m2_req_i.write;
	assign bus_addr_o    = m2_req_i.paddr;
	assign bus_data_ok_o = (state_q == DATA);

	assign done_o = bus_data_ok_o & bus_data_ok_i;
	assign busy_o = m2_req_i.valid | (state_q != IDLE);

endmodule

// File: hdl/lsu_lane_align.sv
`timescale 1ns/1ps
`include "lsu_config.svh"

module lsu_lane_align
	import lsu_pkg::*;
(
	input  logic                   clk,
	input  logic                   rst_n,

	input  lsu_req_t               m2_req_i,
	input  logic [`LSU_DATA_W-1:0] wdata_i,
	input  logic                   done_i,
	input  logic [`LSU_DATA_W-1:0] bus_rdata_i,

	output logic [`LSU_DATA_W-1:0] bus_wdata_o,
	output logic [`LSU_STRB_W-1:0] bus_strb_o,
	output logic [`LSU_DATA_W-1:0] rdata_o
);

	logic [1:0]             offset;
	logic                   zero_ext;
	logic [`LSU_DATA_W-1:0] byte_lane;
	logic [`LSU_DATA_W-1:0] half_lane;
	logic [`LSU_DATA_W-1:0] load_val;

	assign offset   = m2_req_i.paddr[1:0];
	assign zero_ext = m2_req_i.mem_type[2];

	// store data moved up to its byte lane
	assign bus_wdata_o = wdata_i << {offset, 3'b000};

	always_comb begin
		case (m2_req_i.mem_type[1:0])
			SZ_WORD: begin
				bus_strb_o = {`LSU_STRB_W{1'b1}};
			end
			SZ_HALF: begin
				// lanes 0-1 or 2-3 by address bit 1
				bus_strb_o = `LSU_STRB_W'(4'b0011) << {offset[1], 1'b0};
			end
			SZ_BYTE: begin
				bus_strb_o = `LSU_STRB_W'(4'b0001) << offset;
			end
			default: begin
				bus_strb_o = '0;
			end
		endcase
	end

	// load lane brought down to bit 0
	assign byte_lane = bus_rdata_i >> {offset, 3'b000};
	assign half_lane = bus_rdata_i >> {offset[1], 4'b0000};

	always_comb begin
		case (m2_req_i.mem_type[1:0])
			SZ_HALF: begin
				load_val = {{(`LSU_DATA_W-16){half_lane[15] & ~zero_ext}},
					half_lane[15:0]};
			end
			SZ_BYTE: begin
				load_val = {{(`LSU_DATA_W-8){byte_lane[7] & ~zero_ext}},
					byte_lane[7:0]};
			end
			default: begin
				load_val = bus_rdata_i;
			end
		endcase
	end

	// held until the next load completes
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rdata_o <= '0;
		end else if (done_i && !m2_req_i.write) begin
			rdata_o <= load_val;
		end
	end

endmodule

// File: hdl/lsu_top.sv
`timescale 1ns/1ps
`include "lsu_config.svh"

module lsu_top
	import lsu_pkg::*;
(
	input  logic                   clk,
	input  logic                   rst_n,

	// core side
	input  logic                   req_valid_i,
	input  logic                   req_write_i,
	input  mem_type_t              req_type_i,
	input  logic [`LSU_ADDR_W-1:0] vaddr_i,
	input  logic [`LSU_ADDR_W-1:0] paddr_i,
	input  logic [`LSU_DATA_W-1:0] wdata_i,
	input  logic                   flush_m1_i,
	input  logic                   flush_m2_i,
	input  logic                   stall_i,
	output logic                   busy_o,
	output logic [`LSU_DATA_W-1:0] rdata_o,
	output logic [`LSU_ADDR_W-1:0] vaddr_o,
	output logic [`LSU_ADDR_W-1:0] paddr_o,

	// bus side
	output logic                   bus_valid_o,
	output logic                   bus_write_o,
	output logic [`LSU_ADDR_W-1:0] bus_addr_o,
	output logic [`LSU_DATA_W-1:0] bus_wdata_o,
	output logic [`LSU_STRB_W-1:0] bus_strb_o,
	input  logic                   bus_ready_i,
	output logic                   bus_data_ok_o,
	input  logic                   bus_data_ok_i,
	input  logic [`LSU_DATA_W-1:0] bus_rdata_i
);

	lsu_req_t m2_req;
	logic     done;

	lsu_req_pipe lsu_req_pipe_i (
		.clk         (clk),
		.rst_n       (rst_n),
		.req_valid_i (req_valid_i),
		.req_write_i (req_write_i),
		.req_type_i  (req_type_i),
		.vaddr_i     (vaddr_i),
		.paddr_i     (paddr_i),
		.flush_m1_i  (flush_m1_i),
		.flush_m2_i  (flush_m2_i),
		.stall_i     (stall_i),
		.busy_i      (busy_o),
		.done_i      (done),
		.m2_req_o    (m2_req),
		.vaddr_o     (vaddr_o),
		.paddr_o     (paddr_o)
	);

	lsu_bus_fsm lsu_bus_fsm_i (
		.clk           (clk),
		.rst_n         (rst_n),
		.m2_req_i      (m2_req),
		.flush_m2_i    (flush_m2_i),
		.bus_ready_i   (bus_ready_i),
		.bus_data_ok_i (bus_data_ok_i),
		.bus_valid_o   (bus_valid_o),
		.bus_write_o   (bus_write_o),
		.bus_addr_o    (bus_addr_o),
		.bus_data_ok_o (bus_data_ok_o),
		.done_o        (done),
		.busy_o        (busy_o)
	);

	lsu_lane_align lsu_lane_align_i (
		.clk         (clk),
		.rst_n       (rst_n),
		.m2_req_i    (m2_req),
		.wdata_i     (wdata_i),
		.done_i      (done),
		.bus_rdata_i (bus_rdata_i),
		.bus_wdata_o (bus_wdata_o),
		.bus_strb_o  (bus_strb_o),
		.rdata_o     (rdata_o)
	);

endmodule

// File: sim/lsu_tb_clk.sv
`timescale 1ns/1ps

module lsu_tb_clk (
	output logic clk_o,
	output logic rst_n_o
);

	// 20 ns period
	initial begin
		clk_o = 1'b0;
		forever begin
			#10 clk_o = ~clk_o;
		end
	end

	initial begin
		rst_n_o = 1'b0;
		repeat (3) @(posedge clk_o);
		#2 rst_n_o = 1'b1;
	end

endmodule

// File: sim/lsu_tb_mem.sv
`timescale 1ns/1ps
`include "lsu_config.svh"

module lsu_tb_mem (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   valid_i,
	input  logic                   write_i,
	input  logic [`LSU_ADDR_W-1:0] addr_i,
	input  logic [`LSU_DATA_W-1:0] wdata_i,
	input  logic [`LSU_STRB_W-1:0] strb_i,
	input  logic                   data_ok_i,
	output logic                   ready_o,
	output logic                   data_ok_o,
	output logic [`LSU_DATA_W-1:0] rdata_o
);

	logic [`LSU_DATA_W-1:0] mem [0:255];
	logic [`LSU_ADDR_W-1:0] addr_q;
	logic                   write_q;
	logic                   pend;
	logic [1:0]             wait_cnt;
	logic [31:0]            rng;
	logic [7:0]             k;

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// every word differs through its whole index
	initial begin
		for (int i = 0; i < 256; i++) begin
			k = 8'(i);
			mem[i] <= {k, ~k, k ^ 8'h5a, k + 8'h33};
		end
	end

	assign rdata_o = mem[addr_q[9:2]];

	always @(posedge clk) begin
		if (!rst_n) begin
			ready_o   <= 1'b0;
			data_ok_o <= 1'b0;
			pend      <= 1'b0;
			wait_cnt  <= 2'd0;
			addr_q    <= '0;
			write_q   <= 1'b0;
			rng       <= 32'h5651_ca2f;
		end else begin
			if (valid_i && ready_o) begin
				ready_o  <= 1'b0;
				addr_q   <= addr_i;
				write_q  <= write_i;
				pend     <= 1'b1;
				wait_cnt <= rng[1:0];
				rng      <= xorshift(rng);
			end else if (valid_i && !ready_o) begin
				if (wait_cnt == 2'd0) begin
					ready_o <= 1'b1;
				end else begin
					wait_cnt <= wait_cnt - 2'd1;
				end
			end
			if (pend) begin
				if (data_ok_o && data_ok_i) begin
					data_ok_o <= 1'b0;
					pend      <= 1'b0;
					wait_cnt  <= rng[3:2];
					rng       <= xorshift(rng);
					if (write_q) begin
						for (int i = 0; i < 4; i++) begin
							if (strb_i[i]) begin
								mem[addr_q[9:2]][8*i +: 8] <= wdata_i[8*i +: 8];
							end
						end
					end
				end else if (data_ok_i && !data_ok_o) begin
					if (wait_cnt == 2'd0) begin
						data_ok_o <= 1'b1;
					end else begin
						wait_cnt <= wait_cnt - 2'd1;
					end
				end
			end
		end
	end

endmodule

// File: sim/lsu_tb.sv
`timescale 1ns/1ps
`include "lsu_config.svh"

module lsu_tb
	import lsu_pkg::*;
;

	logic                   clk;
	logic                   rst_n;
	logic                   req_valid_i;
	logic                   req_write_i;
	mem_type_t              req_type_i;
	logic [`LSU_ADDR_W-1:0] vaddr_i;
	logic [`LSU_ADDR_W-1:0] paddr_i;
	logic [`LSU_DATA_W-1:0] wdata_i;
	logic                   flush_m1_i;
	logic                   flush_m2_i;
	logic                   stall_i;
	logic                   busy_o;
	logic [`LSU_DATA_W-1:0] rdata_o;
	logic [`LSU_ADDR_W-1:0] vaddr_o;
	logic [`LSU_ADDR_W-1:0] paddr_o;
	logic                   bus_valid_o;
	logic                   bus_write_o;
	logic [`LSU_ADDR_W-1:0] bus_addr_o;
	logic [`LSU_DATA_W-1:0] bus_wdata_o;
	logic [`LSU_STRB_W-1:0] bus_strb_o;
	logic                   bus_ready_i;
	logic                   bus_data_ok_o;
	logic                   bus_data_ok_i;
	logic [`LSU_DATA_W-1:0] bus_rdata_i;

	int          errors;
	int          bus_count;
	logic [31:0] bus_addr_seen;
	logic        bus_write_seen;
	logic [31:0] rng;
	logic [31:0] shadow [0:255];
	logic [7:0]  k;
	logic [31:0] addr;
	logic [31:0] data;
	logic [31:0] old;
	int          n;

	lsu_tb_clk lsu_tb_clk_i (
		.clk_o   (clk),
		.rst_n_o (rst_n)
	);

	lsu_tb_mem lsu_tb_mem_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.valid_i   (bus_valid_o),
		.write_i   (bus_write_o),
		.addr_i    (bus_addr_o),
		.wdata_i   (bus_wdata_o),
		.strb_i    (bus_strb_o),
		.data_ok_i (bus_data_ok_o),
		.ready_o   (bus_ready_i),
		.data_ok_o (bus_data_ok_i),
		.rdata_o   (bus_rdata_i)
	);

	lsu_top lsu_top_i (
		.clk           (clk),
		.rst_n         (rst_n),
		.req_valid_i   (req_valid_i),
		.req_write_i   (req_write_i),
		.req_type_i    (req_type_i),
		.vaddr_i       (vaddr_i),
		.paddr_i       (paddr_i),
		.wdata_i       (wdata_i),
		.flush_m1_i    (flush_m1_i),
		.flush_m2_i    (flush_m2_i),
		.stall_i       (stall_i),
		.busy_o        (busy_o),
		.rdata_o       (rdata_o),
		.vaddr_o       (vaddr_o),
		.paddr_o       (paddr_o),
		.bus_valid_o   (bus_valid_o),
		.bus_write_o   (bus_write_o),
		.bus_addr_o    (bus_addr_o),
		.bus_wdata_o   (bus_wdata_o),
		.bus_strb_o    (bus_strb_o),
		.bus_ready_i   (bus_ready_i),
		.bus_data_ok_o (bus_data_ok_o),
		.bus_data_ok_i (bus_data_ok_i),
		.bus_rdata_i   (bus_rdata_i)
	);

	// address phases seen on the bus
	always @(negedge clk) begin
		if (bus_valid_o && bus_ready_i) begin
			bus_count++;
			bus_addr_seen  = bus_addr_o;
			bus_write_seen = bus_write_o;
		end
	end

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [31:0] ref_load(input logic [31:0] word, input mem_type_t t,
			input logic [31:0] a);
		logic [7:0]  b;
		logic [15:0] h;
		b = word[8*a[1:0] +: 8];
		h = a[1] ? word[31:16] : word[15:0];
		case (t)
			LH:      return {{16{h[15]}}, h};
			LHU:     return {16'h0000, h};
			LB:      return {{24{b[7]}}, b};
			LBU:     return {24'h000000, b};
			default: return word;
		endcase
	endfunction

	function automatic logic [31:0] store_merge(input logic [31:0] prev, input mem_type_t t,
			input logic [31:0] a, input logic [31:0] d);
		logic [31:0] shifted;
		logic [3:0]  lanes;
		logic [31:0] res;
		shifted = d << (8 * a[1:0]);
		case (t)
			LW:      lanes = 4'b1111;
			LH:      lanes = a[1] ? 4'b1100 : 4'b0011;
			default: lanes = 4'b0001 << a[1:0];
		endcase
		res = prev;
		for (int i = 0; i < 4; i++) begin
			if (lanes[i]) begin
				res[8*i +: 8] = shifted[8*i +: 8];
			end
		end
		return res;
	endfunction

	task automatic next_rand(output logic [31:0] r);
		rng = xorshift(rng);
		r = rng;
	endtask

	task automatic check_value(input string name, input logic [31:0] exp,
			input logic [31:0] act);
		if (exp !== act) begin
			errors++;
			$display("Mismatch %s expected %h actual %h", name, exp, act);
		end
	endtask

	// returns at the drive point after the edge where busy_o reached the level
	task automatic wait_busy(input logic level, input logic toggle_stall);
		int   cnt;
		logic seen;
		logic held;
		cnt = 0;
		seen = 1'b0;
		while (!seen && cnt < 200) begin
			// an idle unit under stall keeps its request in M1
			held = stall_i & ~busy_o;
			@(posedge clk);
			#2;
			if (held && busy_o) begin
				errors++;
				$display("request moved to M2 while the pipeline was stalled");
			end
			if (busy_o == level) begin
				seen = 1'b1;
			end else if (toggle_stall) begin
				rng = xorshift(rng);
				stall_i = rng[0];
			end
			cnt++;
		end
		if (!seen) begin
			errors++;
			if (level) begin
				$display("timeout waiting for busy to rise");
			end else begin
				$display("timeout waiting for busy to fall");
			end
		end
	endtask

	task automatic issue(input logic wr, input mem_type_t t, input logic [31:0] a,
			input logic [31:0] d);
		req_valid_i = 1'b1;
		req_write_i = wr;
		req_type_i  = t;
		vaddr_i     = a | 32'h4000_0000;
		paddr_i     = a;
		wdata_i     = d;
		@(posedge clk);
		#2 req_valid_i = 1'b0;
	endtask

	task automatic access(input string name, input logic wr, input mem_type_t t,
			input logic [31:0] a, input logic [31:0] d);
		issue(wr, t, a, d);
		wait_busy(1'b1, 1'b0);
		wait_busy(1'b0, 1'b0);
		check_value({name, " bus addr"}, a, bus_addr_seen);
		check_value({name, " bus write"}, 32'(wr), 32'(bus_write_seen));
		if (wr) begin
			shadow[a[9:2]] = store_merge(shadow[a[9:2]], t, a, d);
		end else begin
			check_value(name, ref_load(shadow[a[9:2]], t, a), rdata_o);
		end
	endtask

	// in_m2 picks which stage holds the request when it is flushed
	task automatic flushed_access(input logic in_m2, input logic wr, input mem_type_t t,
			input logic [31:0] a, input logic [31:0] d);
		int          cnt_before;
		logic [31:0] rdata_before;
		cnt_before = bus_count;
		rdata_before = rdata_o;
		issue(wr, t, a, d);
		if (in_m2) begin
			@(posedge clk);
			#2 flush_m2_i = 1'b1;
		end else begin
			flush_m1_i = 1'b1;
		end
		@(posedge clk);
		#2;
		flush_m1_i = 1'b0;
		flush_m2_i = 1'b0;
		repeat (4) @(posedge clk);
		#2;
		if (busy_o) begin
			errors++;
			$display("busy stayed high after a flushed request");
		end
		check_value("flush bus transfers", 32'(cnt_before), 32'(bus_count));
		if (!wr) begin
			check_value("flush load rdata", rdata_before, rdata_o);
		end
	endtask

	// A is on the bus while B waits in M1
	task automatic pair_access(input logic a_wr, input mem_type_t a_t, input logic [31:0] a_a,
			input logic [31:0] a_d, input mem_type_t b_t, input logic [31:0] b_a);
		stall_i = 1'b0;
		issue(a_wr, a_t, a_a, a_d);
		req_valid_i = 1'b1;
		req_write_i = 1'b0;
		req_type_i  = b_t;
		vaddr_i     = b_a | 32'h4000_0000;
		@(posedge clk);
		#2 req_valid_i = 1'b0;
		wait_busy(1'b0, 1'b1);
		check_value("pair first bus addr", a_a, bus_addr_seen);
		if (a_wr) begin
			shadow[a_a[9:2]] = store_merge(shadow[a_a[9:2]], a_t, a_a, a_d);
		end else begin
			check_value("pair first load", ref_load(shadow[a_a[9:2]], a_t, a_a), rdata_o);
		end
		paddr_i = b_a;
		wait_busy(1'b1, 1'b1);
		check_value("pair vaddr_o", b_a | 32'h4000_0000, vaddr_o);
		check_value("pair paddr_o", b_a, paddr_o);
		stall_i = 1'b0;
		wait_busy(1'b0, 1'b0);
		check_value("pair second bus addr", b_a, bus_addr_seen);
		check_value("pair second load", ref_load(shadow[b_a[9:2]], b_t, b_a), rdata_o);
	endtask

	initial begin
		req_valid_i    = 1'b0;
		req_write_i    = 1'b0;
		req_type_i     = LW;
		vaddr_i        = '0;
		paddr_i        = '0;
		wdata_i        = '0;
		flush_m1_i     = 1'b0;
		flush_m2_i     = 1'b0;
		stall_i        = 1'b0;
		errors         = 0;
		bus_count      = 0;
		bus_addr_seen  = '0;
		bus_write_seen = 1'b0;
		rng            = 32'h5651_ca2f;
		// same fill as the memory model
		for (int i = 0; i < 256; i++) begin
			k = 8'(i);
			shadow[i] = {k, ~k, k ^ 8'h5a, k + 8'h33};
		end

		n = 0;
		while (rst_n !== 1'b1 && n < 20) begin
			@(posedge clk);
			n++;
		end
		if (rst_n !== 1'b1) begin
			errors++;
			$display("reset never released");
		end
		@(posedge clk);
		#2;

		// word round trip
		repeat (20) begin
			next_rand(addr);
			addr = {22'd0, addr[9:2], 2'b00};
			next_rand(data);
			access("word store", 1'b1, SW, addr, data);
			access("word round trip", 1'b0, LW, addr, 32'd0);
		end

		// narrow stores only touch their lanes
		next_rand(addr);
		addr = {22'd0, addr[9:2], 2'b00};
		for (int off = 0; off < 4; off++) begin
			next_rand(data);
			access("byte store", 1'b1, SB, addr + 32'(off), data);
			access("byte store lanes", 1'b0, LW, addr, 32'd0);
		end
		for (int off = 0; off < 4; off += 2) begin
			next_rand(data);
			access("half store", 1'b1, SH, addr + 32'(off), data);
			access("half store lanes", 1'b0, LW, addr, 32'd0);
		end

		// sign and zero extension
		repeat (4) begin
			next_rand(addr);
			addr = {22'd0, addr[9:2], 2'b00};
			next_rand(data);
			access("ext setup", 1'b1, SW, addr, data);
			for (int off = 0; off < 4; off++) begin
				access("load LB", 1'b0, LB, addr + 32'(off), 32'd0);
				access("load LBU", 1'b0, LBU, addr + 32'(off), 32'd0);
			end
			for (int off = 0; off < 4; off += 2) begin
				access("load LH", 1'b0, LH, addr + 32'(off), 32'd0);
				access("load LHU", 1'b0, LHU, addr + 32'(off), 32'd0);
			end
		end

		// flushed requests never reach the bus
		access("flush prep", 1'b0, LW, 32'h0000_0010, 32'd0);
		flushed_access(1'b0, 1'b1, SW, 32'h0000_0010, 32'hdead_beef);
		flushed_access(1'b1, 1'b1, SB, 32'h0000_0011, 32'h0000_00aa);
		flushed_access(1'b0, 1'b0, LB, 32'h0000_0020, 32'd0);
		flushed_access(1'b1, 1'b0, LHU, 32'h0000_0022, 32'd0);
		access("flushed store memory", 1'b0, LW, 32'h0000_0010, 32'd0);

		// back to back under stall and slave delay
		repeat (6) begin
			next_rand(addr);
			addr = {22'd0, addr[9:2], 2'b00};
			next_rand(data);
			pair_access(1'b1, SW, addr, data, LW, addr);
			next_rand(old);
			old = {22'd0, old[9:2], 2'b00};
			pair_access(1'b0, LBU, addr + 32'd3, 32'd0, LH, old + 32'd2);
		end

		$display("checks done, %0d errors", errors);
		if (errors == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

// File: lsu.f
+incdir+hdl
hdl/lsu_pkg.sv
hdl/lsu_req_pipe.sv
hdl/lsu_bus_fsm.sv
hdl/lsu_lane_align.sv
hdl/lsu_top.sv
sim/lsu_tb_clk.sv
sim/lsu_tb_mem.sv
sim/lsu_tb.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing
TOP      = lsu_tb
FILELIST = lsu.f
OBJDIR   = obj_dir
PASS     = ALL CHECKS PASSED

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -o V$(TOP)

run: compile
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^$(PASS)$$"

clean:
	rm -rf $(OBJDIR)
